/* design/noc_flit_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths and flit types for the router port flit path.
// Imported by wildcard into every design module; the flit
// layout here fixes field positions for builder, update stage
// and extractor alike.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package noc_flit_pkg;

    localparam int V       = 4;  // virtual channels per port
    localparam int VW      = 2;  // vc index width
    localparam int EAW     = 4;  // endpoint address width
    localparam int DSTPW   = 4;  // destination port field
    localparam int CW      = 2;  // message class field
    localparam int WEIGHTW = 4;  // wrr weight field
    localparam int FPAY    = 32; // payload width

    // optional header data takes whatever the control fields leave over
    localparam int HDR_DATAW = FPAY - 2 * EAW - DSTPW - CW - WEIGHTW;

    // header payload, msb first
    typedef struct packed {
        logic [HDR_DATAW-1:0] data;
        logic [WEIGHTW-1:0]   weight;
        logic [CW-1:0]        flit_class;
        logic [DSTPW-1:0]     destport;
        logic [EAW-1:0]       dest_addr;
        logic [EAW-1:0]       src_addr;   // lsbs of the payload
    } hdr_fields_t;

    // one payload word, read per flit type
    typedef union packed {
        hdr_fields_t     hdr;  // header flit view
        logic [FPAY-1:0] word; // body flit view
    } flit_payload_t;

    typedef struct packed {
        logic          hdr_flg;
        logic          tail_flg;
        logic [V-1:0]  vc;      // one-hot
        flit_payload_t payload;
    } flit_t;

    // injection request from the local endpoint
    typedef struct packed {
        hdr_fields_t     hdr;
        logic [FPAY-1:0] body;
        logic [VW-1:0]   vc_idx;
        logic            tail;   // body flits only
    } inject_req_t;

    // decoded view at the output side
    typedef struct packed {
        logic [EAW-1:0]       src_addr;
        logic [EAW-1:0]       dest_addr;
        logic [DSTPW-1:0]     destport;
        logic [CW-1:0]        flit_class;
        logic [WEIGHTW-1:0]   weight;
        logic [HDR_DATAW-1:0] data;
        logic                 hdr_flg;
        logic                 tail_flg;
        logic [V-1:0]         vc;        // one-hot
    } hdr_info_t;

endpackage

/* design/hdr_flit_builder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input side of the flit path. Packs an injection request into
// a header or body flit and tags it with a one-hot VC.
// Flit leaves one cycle after the inject strobe.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module hdr_flit_builder
    import noc_flit_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  inject_req_t req_i,
    input  logic        hdr_inject_i,  // send header flit
    input  logic        body_inject_i, // send body flit
    output flit_t       flit_o,
    output logic        flit_valid_o
);

    logic  [V-1:0] vc_oh;
    logic          inject;
    flit_t         flit_nxt;

    assign vc_oh  = {{(V-1){1'b0}}, 1'b1} << req_i.vc_idx;
    assign inject = hdr_inject_i | body_inject_i;

    always_comb begin
        flit_nxt.vc = vc_oh;
        if (hdr_inject_i) begin        // header wins over body
            flit_nxt.hdr_flg     = 1'b1;
            flit_nxt.tail_flg    = 1'b0;
            flit_nxt.payload.hdr = req_i.hdr;
        end else begin
            flit_nxt.hdr_flg      = 1'b0;
            flit_nxt.tail_flg     = req_i.tail;
            flit_nxt.payload.word = req_i.body;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_valid_o <= 1'b0;
        end else begin
            flit_valid_o <= inject;
        end
    end

    // flit contents only matter while valid
    always_ff @(posedge clk) begin
        if (inject) begin
            flit_o <= flit_nxt;
        end
    end

endmodule

/* design/lk_route_ovc_update.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Look-ahead route and output VC rewrite stage. Holds one
// destination port and one output VC per input VC, written
// from outside, and rewrites each passing flit in one cycle.
// Weight overwrite on header flits when WRRA_EN is set.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module lk_route_ovc_update
    import noc_flit_pkg::*;
#(
    parameter bit WRRA_EN = 1'b1
) (
    input  logic               clk,
    input  logic               reset,
    input  flit_t              flit_i,
    input  logic               flit_valid_i,
    input  logic               route_wr_i,
    input  logic [VW-1:0]      route_vc_i,
    input  logic [DSTPW-1:0]   route_port_i,
    input  logic               ovc_wr_i,
    input  logic [VW-1:0]      ovc_vc_i,
    input  logic [V-1:0]       ovc_num_i,    // one-hot
    input  logic [WEIGHTW-1:0] weight_cfg_i,
    output flit_t              flit_o,
    output logic               flit_valid_o
);

    logic [DSTPW-1:0] route_tbl [V];
    logic [V-1:0]     ovc_tbl   [V];
    logic [DSTPW-1:0] lk_port;
    logic [V-1:0]     ovc_sel;
    flit_t            flit_nxt;

    // table writes land at the edge, so a same-cycle reader sees old data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < V; i++) begin
                route_tbl[i] <= '0;
                ovc_tbl[i]   <= {{(V-1){1'b0}}, 1'b1} << i; // identity mapping
            end
        end else begin
            if (route_wr_i) begin
                route_tbl[route_vc_i] <= route_port_i;
            end
            if (ovc_wr_i) begin
                ovc_tbl[ovc_vc_i] <= ovc_num_i;
            end
        end
    end

    // one-hot selected table read
    always_comb begin
        lk_port = '0;
        ovc_sel = '0;
        for (int i = 0; i < V; i++) begin
            if (flit_i.vc[i]) begin
                lk_port = lk_port | route_tbl[i];
                ovc_sel = ovc_sel | ovc_tbl[i];
            end
        end
    end

    always_comb begin
        flit_nxt    = flit_i;
        flit_nxt.vc = ovc_sel;                    // every flit
        if (flit_i.hdr_flg) begin
            flit_nxt.payload.hdr.destport = lk_port;
            if (WRRA_EN) begin
                flit_nxt.payload.hdr.weight = weight_cfg_i;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_valid_o <= 1'b0;
        end else begin
            flit_valid_o <= flit_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (flit_valid_i) begin
            flit_o <= flit_nxt;
        end
    end

endmodule

/* design/hdr_flit_extract.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output side of the flit path. Decodes a flit into header
// fields, flags and payload word, registered for one cycle.
// hdr_wr_o pulses the flit's VC when a header flit leaves.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module hdr_flit_extract
    import noc_flit_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  flit_t           flit_i,
    input  logic            flit_valid_i,
    output hdr_info_t       info_o,
    output logic [FPAY-1:0] data_o,
    output logic            out_valid_o,
    output logic [V-1:0]    hdr_wr_o      // per vc header write
);

    hdr_info_t   info_nxt;
    hdr_fields_t hdr;

    assign hdr = flit_i.payload.hdr;   // header view of the word

    always_comb begin
        info_nxt.src_addr   = hdr.src_addr;
        info_nxt.dest_addr  = hdr.dest_addr;
        info_nxt.destport   = hdr.destport;
        info_nxt.flit_class = hdr.flit_class;
        info_nxt.weight     = hdr.weight;
        info_nxt.data       = hdr.data;
        info_nxt.hdr_flg    = flit_i.hdr_flg;
        info_nxt.tail_flg   = flit_i.tail_flg;
        info_nxt.vc         = flit_i.vc;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid_o <= 1'b0;
            hdr_wr_o    <= '0;
        end else begin
            out_valid_o <= flit_valid_i;
            hdr_wr_o    <= (flit_valid_i && flit_i.hdr_flg) ? flit_i.vc : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (flit_valid_i) begin
            info_o <= info_nxt;
            data_o <= flit_i.payload.word; // body view
        end
    end

endmodule

/* design/flit_path_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the flit path: builder, route/VC update, extractor.
// Three cycles from inject strobe to out_valid_o.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module flit_path_top
    import noc_flit_pkg::*;
#(
    parameter bit WRRA_EN = 1'b1
) (
    input  logic               clk,
    input  logic               reset,
    input  inject_req_t        req_i,
    input  logic               hdr_inject_i,
    input  logic               body_inject_i,
    input  logic               route_wr_i,
    input  logic [VW-1:0]      route_vc_i,
    input  logic [DSTPW-1:0]   route_port_i,
    input  logic               ovc_wr_i,
    input  logic [VW-1:0]      ovc_vc_i,
    input  logic [V-1:0]       ovc_num_i,
    input  logic [WEIGHTW-1:0] weight_cfg_i,
    output hdr_info_t          info_o,
    output logic [FPAY-1:0]    data_o,
    output logic               out_valid_o,
    output logic [V-1:0]       hdr_wr_o
);

    flit_t bld_flit;
    logic  bld_valid;
    flit_t upd_flit;
    logic  upd_valid;

    hdr_flit_builder u_builder (
        .clk           (clk),
        .reset         (reset),
        .req_i         (req_i),
        .hdr_inject_i  (hdr_inject_i),
        .body_inject_i (body_inject_i),
        .flit_o        (bld_flit),
        .flit_valid_o  (bld_valid)
    );

    lk_route_ovc_update #(
        .WRRA_EN (WRRA_EN)
    ) u_update (
        .clk          (clk),
        .reset        (reset),
        .flit_i       (bld_flit),
        .flit_valid_i (bld_valid),
        .route_wr_i   (route_wr_i),
        .route_vc_i   (route_vc_i),
        .route_port_i (route_port_i),
        .ovc_wr_i     (ovc_wr_i),
        .ovc_vc_i     (ovc_vc_i),
        .ovc_num_i    (ovc_num_i),
        .weight_cfg_i (weight_cfg_i),
        .flit_o       (upd_flit),
        .flit_valid_o (upd_valid)
    );

    hdr_flit_extract u_extract (
        .clk          (clk),
        .reset        (reset),
        .flit_i       (upd_flit),
        .flit_valid_i (upd_valid),
        .info_o       (info_o),
        .data_o       (data_o),
        .out_valid_o  (out_valid_o),
        .hdr_wr_o     (hdr_wr_o)
    );

endmodule

/* tb/clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source. Free-running clock and an
// active high reset held for the first few rising edges.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD       = 20, // ns
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_o <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;                        // released on an edge
    end

endmodule

/* tb/flit_path_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the flit path top level, bound into
// every flit_path_top instance. Covers the header write strobe
// shape and the fixed inject to output latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module flit_path_sva
    import noc_flit_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input logic         hdr_inject_i,
    input logic         body_inject_i,
    input logic         out_valid_i,
    input logic [V-1:0] hdr_wr_i
);

    a_wr_onehot : assert property (@(posedge clk) disable iff (reset)
        $onehot0(hdr_wr_i))
        else $error("hdr_wr_o has more than one bit set");

    a_wr_needs_valid : assert property (@(posedge clk) disable iff (reset)
        (hdr_wr_i != '0) |-> out_valid_i)
        else $error("hdr_wr_o raised without out_valid_o");

    // both directions: no early, late or spurious output
    a_latency : assert property (@(posedge clk) disable iff (reset)
        out_valid_i == $past(hdr_inject_i | body_inject_i, 3))
        else $error("out_valid_o not three cycles after an inject strobe");

endmodule

bind flit_path_top flit_path_sva u_sva (
    .clk           (clk),
    .reset         (reset),
    .hdr_inject_i  (hdr_inject_i),
    .body_inject_i (body_inject_i),
    .out_valid_i   (out_valid_o),
    .hdr_wr_i      (hdr_wr_o)
);

/* tb/flit_path_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the flit path. Each test injects
// flits, keeps its own model of both tables and queues the
// expected output; a negedge monitor compares in order.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module flit_path_tb
    import noc_flit_pkg::*;
();

    // about 105 cycles of tests plus slack
    localparam int TEST_CYCLES = 110;
    localparam int CYCLE_LIMIT = TEST_CYCLES + 100;

    typedef struct packed {
        hdr_info_t       info;
        logic [FPAY-1:0] data;
        logic [V-1:0]    wr;
    } exp_t;

    logic               clk;
    logic               reset;
    inject_req_t        req_i;
    logic               hdr_inject_i;
    logic               body_inject_i;
    logic               route_wr_i;
    logic [VW-1:0]      route_vc_i;
    logic [DSTPW-1:0]   route_port_i;
    logic               ovc_wr_i;
    logic [VW-1:0]      ovc_vc_i;
    logic [V-1:0]       ovc_num_i;
    logic [WEIGHTW-1:0] weight_cfg_i;
    hdr_info_t          info_o;
    logic [FPAY-1:0]    data_o;
    logic               out_valid_o;
    logic [V-1:0]       hdr_wr_o;

    logic [DSTPW-1:0]   route_model [V];   // expected table contents
    logic [V-1:0]       ovc_model   [V];
    logic [WEIGHTW-1:0] weight_val;
    exp_t               exp_q [$];
    int                 cycle_cnt  = 0;
    int                 hdr_errs   = 0;
    int                 data_errs  = 0;
    int                 wr_errs    = 0;
    int                 other_errs = 0;

    clk_gen #(.PERIOD(20), .RESET_CYCLES(3)) u_clk_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    flit_path_top #(.WRRA_EN(1'b1)) DUT (
        .clk           (clk),
        .reset         (reset),
        .req_i         (req_i),
        .hdr_inject_i  (hdr_inject_i),
        .body_inject_i (body_inject_i),
        .route_wr_i    (route_wr_i),
        .route_vc_i    (route_vc_i),
        .route_port_i  (route_port_i),
        .ovc_wr_i      (ovc_wr_i),
        .ovc_vc_i      (ovc_vc_i),
        .ovc_num_i     (ovc_num_i),
        .weight_cfg_i  (weight_cfg_i),
        .info_o        (info_o),
        .data_o        (data_o),
        .out_valid_o   (out_valid_o),
        .hdr_wr_o      (hdr_wr_o)
    );

    task automatic check_hdr(input hdr_info_t got, input hdr_info_t exp);
        if (got !== exp) begin
            hdr_errs++;
            $display("** Error at %0t: header info got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_data(input logic [FPAY-1:0] got, input logic [FPAY-1:0] exp);
        if (got !== exp) begin
            data_errs++;
            $display("** Error at %0t: payload got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_wr(input logic [V-1:0] got, input logic [V-1:0] exp);
        if (got !== exp) begin
            wr_errs++;
            $display("** Error at %0t: hdr_wr_o got %b expected %b", $time, got, exp);
        end
    endtask

    // header view of a payload word plus flags as the output side shows it
    function automatic hdr_info_t decode_view(hdr_fields_t f, logic hdr, logic tail,
                                              logic [V-1:0] vc);
        hdr_info_t d;
        d.src_addr   = f.src_addr;
        d.dest_addr  = f.dest_addr;
        d.destport   = f.destport;
        d.flit_class = f.flit_class;
        d.weight     = f.weight;
        d.data       = f.data;
        d.hdr_flg    = hdr;
        d.tail_flg   = tail;
        d.vc         = vc;
        return d;
    endfunction

    function automatic exp_t expect_hdr(logic [VW-1:0] k, hdr_fields_t h);
        exp_t        e;
        hdr_fields_t m;
        m          = h;
        m.destport = route_model[k];
        m.weight   = weight_val;            // weighted round-robin on
        e.info     = decode_view(m, 1'b1, 1'b0, ovc_model[k]);
        e.data     = m;
        e.wr       = ovc_model[k];
        return e;
    endfunction

    function automatic exp_t expect_body(logic [VW-1:0] k, logic [FPAY-1:0] w, logic t);
        exp_t e;
        e.info = decode_view(hdr_fields_t'(w), 1'b0, t, ovc_model[k]);
        e.data = w;
        e.wr   = '0;
        return e;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            hdr_inject_i  <= 1'b0;
            body_inject_i <= 1'b0;
            route_wr_i    <= 1'b0;
            ovc_wr_i      <= 1'b0;
        end
    endtask

    task automatic send_hdr(input logic [VW-1:0] k, input hdr_fields_t h);
        logic [FPAY-1:0] noise;
        logic            tail_noise;
        logic            body_too;
        noise      = $urandom;
        tail_noise = 1'($urandom);
        body_too   = 1'($urandom);
        @(posedge clk);
        req_i.hdr     <= h;
        req_i.body    <= noise;
        req_i.vc_idx  <= k;
        req_i.tail    <= tail_noise;
        hdr_inject_i  <= 1'b1;
        body_inject_i <= body_too;           // header still has to win
        route_wr_i    <= 1'b0;
        ovc_wr_i      <= 1'b0;
        exp_q.push_back(expect_hdr(k, h));
    endtask

    task automatic send_body(input logic [VW-1:0] k, input logic [FPAY-1:0] w,
                             input logic t);
        hdr_fields_t noise;
        noise = $urandom;
        @(posedge clk);
        req_i.hdr     <= noise;
        req_i.body    <= w;
        req_i.vc_idx  <= k;
        req_i.tail    <= t;
        hdr_inject_i  <= 1'b0;
        body_inject_i <= 1'b1;
        route_wr_i    <= 1'b0;
        ovc_wr_i      <= 1'b0;
        exp_q.push_back(expect_body(k, w, t));
    endtask

    task automatic write_route(input logic [VW-1:0] k, input logic [DSTPW-1:0] p);
        @(posedge clk);
        route_wr_i    <= 1'b1;
        route_vc_i    <= k;
        route_port_i  <= p;
        ovc_wr_i      <= 1'b0;
        hdr_inject_i  <= 1'b0;
        body_inject_i <= 1'b0;
        route_model[k] = p;
    endtask

    task automatic write_ovc(input logic [VW-1:0] k, input logic [V-1:0] oh);
        @(posedge clk);
        ovc_wr_i      <= 1'b1;
        ovc_vc_i      <= k;
        ovc_num_i     <= oh;
        route_wr_i    <= 1'b0;
        hdr_inject_i  <= 1'b0;
        body_inject_i <= 1'b0;
        ovc_model[k] = oh;
    endtask

    // wait until every queued flit has come out
    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) begin
            idle(1);
        end
        idle(1);
    endtask

    task automatic test_reset_and_header();
        idle(4);                             // monitor flags any early output
        send_hdr(VW'($urandom), hdr_fields_t'($urandom));
        drain();
    endtask

    task automatic test_body_flits();
        for (int i = 0; i < 6; i++) begin
            send_body(VW'(i), $urandom, 1'($urandom));
            idle(1);
        end
        drain();
    endtask

    task automatic test_route_table();
        for (int i = 0; i < V; i++) begin
            write_route(VW'(i), DSTPW'($urandom));
        end
        idle(1);
        for (int i = 0; i < V; i++) begin
            send_hdr(VW'(i), hdr_fields_t'($urandom));
            send_body(VW'(i), $urandom, 1'($urandom));
        end
        drain();
    endtask

    task automatic test_ovc_table();
        for (int i = 0; i < V; i++) begin
            write_ovc(VW'(i), V'(1) << VW'($urandom));
        end
        idle(1);
        for (int i = 0; i < V; i++) begin
            send_body(VW'(i), $urandom, 1'($urandom));
            send_hdr(VW'(i), hdr_fields_t'($urandom));
        end
        drain();
    endtask

    task automatic test_back_to_back();
        for (int i = 0; i < 32; i++) begin
            if (1'($urandom)) begin
                send_hdr(VW'(i), hdr_fields_t'($urandom));
            end else begin
                send_body(VW'(i), $urandom, 1'($urandom));
            end
        end
        drain();
    endtask

    // outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        exp_t e;
        if (!reset) begin
            if (out_valid_o) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("Output flit at %0t with no flit waiting for it", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_hdr(info_o, e.info);
                    check_data(data_o, e.data);
                    check_wr(hdr_wr_o, e.wr);
                end
            end else begin
                check_wr(hdr_wr_o, '0);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int total;
        weight_val = WEIGHTW'($urandom(32'hc0019e45)); // first draw also seeds the stream
        for (int i = 0; i < V; i++) begin
            route_model[i] = '0;
            ovc_model[i]   = V'(1) << i;     // identity after reset
        end
        req_i         <= '0;
        hdr_inject_i  <= 1'b0;
        body_inject_i <= 1'b0;
        route_wr_i    <= 1'b0;
        route_vc_i    <= '0;
        route_port_i  <= '0;
        ovc_wr_i      <= 1'b0;
        ovc_vc_i      <= '0;
        ovc_num_i     <= '0;
        weight_cfg_i  <= weight_val;
        @(negedge reset);
        test_reset_and_header();
        test_body_flits();
        test_route_table();
        test_ovc_table();
        test_back_to_back();
        total = hdr_errs + data_errs + wr_errs + other_errs;
        $display("errors: header %0d, payload %0d, write strobe %0d, other %0d",
                 hdr_errs, data_errs, wr_errs, other_errs);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
design/noc_flit_pkg.sv
design/hdr_flit_builder.sv
design/lk_route_ovc_update.sv
design/hdr_flit_extract.sv
design/flit_path_top.sv
tb/clk_gen.sv
tb/flit_path_sva.sv
tb/flit_path_tb.sv

/* Makefile */
SIM      = verilator
VFLAGS   = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP      = flit_path_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = TEST RESULT: FAIL
PASS_MSG = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
